/* src/zx_host_params.svh */
/*
 * Widths, port decodes, bank numbers and turbo masks for the Z80 host glue.
 * The bank and ROM constants assume 16K pages and a 32M byte RAM space.
 */
`ifndef ZX_HOST_PARAMS_SVH
`define ZX_HOST_PARAMS_SVH

`define ADDR_W       16
`define DATA_W       8
`define RAM_ADDR_W   25
`define AUDIO_W      16

// ROM pages sit above the RAM banks
`define ROM_BASE     5'h17

// Port FE decode is addr bit 0 low
`define PORT_ULA_MASK 16'h0001
`define PORT_PROFI   16'hDFFD

`define BANK_4000    6'd5
`define BANK_8000    6'd2

// Divider masks get narrower as the turbo level rises
`define TURBO_MASK_0 5'b11111
`define TURBO_MASK_1 5'b01111
`define TURBO_MASK_2 5'b00111
`define TURBO_MASK_3 5'b00011

`define CE_PSG_DIV   64

`endif

/* src/zx_host_pkg.sv */
/*
 * Shared types for the host glue. Widths come from the params header.
 */
`include "zx_host_params.svh"

package zx_host_pkg;

	typedef logic [`ADDR_W-1:0]     cpu_addr_t;
	typedef logic [`DATA_W-1:0]     byte_t;
	typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [5:0]             bank_t;
	typedef logic [`AUDIO_W-1:0]    audio_t;
	typedef logic [4:0]             turbo_mask_t;

	typedef enum logic [1:0] {
		MEM_48K,
		MEM_128K,
		MEM_P512,
		MEM_P1024
	} mem_model_e;

	typedef enum logic [1:0] {
		TURBO_X1,
		TURBO_X2,
		TURBO_X4,
		TURBO_X8
	} turbo_e;

	// State of the CPU enable gate
	typedef enum logic [1:0] {
		CE_RUN,
		CE_SETTLE,
		CE_HOLD
	} cpu_phase_e;

endpackage

/* src/zx_bus_if.sv */
/*
 * Decoded CPU bus. Strobes are single-cycle, with no back-pressure.
 * addr and dout follow the pins with no register.
 */
`timescale 1ns/100ps

interface zx_bus_if import zx_host_pkg::*; ();

	cpu_addr_t addr;
	byte_t     dout;
	logic      mem_rd;
	logic      mem_wr;
	logic      io_wr_stb;
	logic      m1_stb;

	// Driven by the bus decoder
	modport master (
		output addr, dout, mem_rd, mem_wr, io_wr_stb, m1_stb
	);

	// Read by the pager and the ULA port
	modport target (
		input addr, dout, mem_rd, mem_wr, io_wr_stb, m1_stb
	);

endinterface

/* src/bus_decoder.sv */
/*
 * Raw Z80 pins to decoded bus. Strobes fire on the first clock after
 * the cycle starts, so the pins must hold for at least two clocks.
 */
`timescale 1ns/100ps
`include "zx_host_params.svh"

module bus_decoder import zx_host_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      mreq_n,
	input  logic      iorq_n,
	input  logic      rd_n,
	input  logic      wr_n,
	input  logic      m1_n,
	input  cpu_addr_t addr,
	input  byte_t     cpu_dout,
	input  byte_t     ram_dout,
	input  byte_t     psg_dout,
	input  byte_t     ula_din,
	zx_bus_if.master  bus,
	output byte_t     cpu_din
);

	logic io_wr, io_rd, m1;
	logic io_wr_d, m1_d;
	logic is_psg, is_ula;

	assign io_wr = ~iorq_n & ~wr_n & m1_n;
	assign io_rd = ~iorq_n & ~rd_n & m1_n;
	assign m1    = ~m1_n & ~mreq_n;

	assign bus.addr   = addr;
	assign bus.dout   = cpu_dout;
	assign bus.mem_rd = ~mreq_n & ~rd_n;
	assign bus.mem_wr = ~mreq_n & ~wr_n;

	// Rising edge of each cycle type
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d       <= 1'b0;
			m1_d          <= 1'b0;
			bus.io_wr_stb <= 1'b0;
			bus.m1_stb    <= 1'b0;
		end else begin
			io_wr_d       <= io_wr;
			m1_d          <= m1;
			bus.io_wr_stb <= io_wr & ~io_wr_d;
			bus.m1_stb    <= m1 & ~m1_d;
		end
	end

	// FFFD is the sound chip register port
	assign is_psg = addr[15] & (addr[1:0] == 2'b01);
	assign is_ula = (addr & `PORT_ULA_MASK) == '0;

	always_comb begin
		if (bus.mem_rd)
			cpu_din = ram_dout;
		else if (io_rd & is_psg)
			cpu_din = psg_dout;
		else if (io_rd & is_ula)
			cpu_din = ula_din;
		else
			cpu_din = 8'hFF;
	end

endmodule

/* src/clock_enables.sv */
/*
 * CPU and sound-chip clock enables from one free counter.
 * A turbo change blanks the CPU enables for at least three slots.
 * RAM wait only stalls the CPU at the fastest turbo level.
 */
`timescale 1ns/100ps
`include "zx_host_params.svh"

module clock_enables import zx_host_pkg::*; (
	input  logic   clk_sys,
	input  logic   reset,
	input  turbo_e turbo_sel,
	input  logic   pause,
	input  logic   ram_ready,
	output logic   ce_cpu_p,
	output logic   ce_cpu_n,
	output logic   ce_psg
);

	localparam int CNT_W = $clog2(`CE_PSG_DIV);

	logic [CNT_W-1:0] counter;
	turbo_mask_t      mask, req_mask, masked;
	logic             tp, tn;
	logic             hold_req;
	logic [1:0]       settle_cnt;
	cpu_phase_e       phase;

	always_comb begin
		case (turbo_sel)
			TURBO_X2: req_mask = `TURBO_MASK_1;
			TURBO_X4: req_mask = `TURBO_MASK_2;
			TURBO_X8: req_mask = `TURBO_MASK_3;
			default:  req_mask = `TURBO_MASK_0;
		endcase
	end

	assign masked = counter[4:0] & mask;

	// ==================== divider
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			ce_psg  <= 1'b0;
			tp      <= 1'b0;
			tn      <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			ce_psg  <= (counter == '0) & ~pause;
			tp      <= masked == '0;
			// Half period has the top mask bit set and the lower bits clear
			tn      <= (masked ^ mask ^ {1'b0, mask[4:1]}) == '0;
		end
	end

	// ==================== run gate
	assign hold_req = pause | ((mask == `TURBO_MASK_3) & ~ram_ready);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase      <= CE_RUN;
			mask       <= `TURBO_MASK_0;
			settle_cnt <= 2'd0;
		end else if (tn) begin
			if (mask != req_mask) begin
				mask       <= req_mask;
				phase      <= CE_SETTLE;
				settle_cnt <= 2'd1;
			end else begin
				case (phase)
					CE_SETTLE: begin
						if (settle_cnt != 2'd0)
							settle_cnt <= settle_cnt + 2'd1;
						else if (ram_ready)
							phase <= pause ? CE_HOLD : CE_RUN;
					end
					CE_RUN:  if (hold_req) phase <= CE_HOLD;
					CE_HOLD: if (!hold_req) phase <= CE_RUN;
					default: phase <= CE_RUN;
				endcase
			end
		end
	end

	assign ce_cpu_p = (phase == CE_RUN) & tp;
	assign ce_cpu_n = (phase == CE_RUN) & tn;

endmodule

/* src/memory_pager.sv */
/*
 * 7FFD and DFFD paging with the 16K window map.
 * The memory model is taken only while reset is high.
 * Window 0 is always ROM and never written.
 */
`timescale 1ns/100ps
`include "zx_host_params.svh"

module memory_pager import zx_host_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  mem_model_e mem_model,
	zx_bus_if.target   bus,
	output ram_addr_t  ram_addr,
	output logic       ram_rd,
	output logic       ram_we,
	output byte_t      ram_din
);

	mem_model_e model;
	byte_t      page_reg;
	logic [2:0] page_ext;
	logic       zx48;
	logic       page_write;
	logic       profi_write;
	logic [1:0] page_rom;
	bank_t      bank;
	logic [1:0] window;

	assign zx48 = model == MEM_48K;

	// Partial 7FFD decode on addr bits 15 and 1 low
	assign page_write  = bus.io_wr_stb & ~bus.addr[15] & ~bus.addr[1]
		& ~(zx48 | page_reg[5]);
	assign profi_write = bus.io_wr_stb & (model == MEM_P1024)
		& (bus.addr == `PORT_PROFI);

	// ==================== paging registers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model    <= mem_model;
			page_reg <= '0;
			page_ext <= '0;
		end else begin
			if (page_write) begin
				page_reg <= bus.dout;
				// Pentagon 512 takes the high bank bits from 7FFD
				if (model == MEM_P512)
					page_ext[1:0] <= bus.dout[7:6];
			end
			if (profi_write)
				page_ext <= bus.dout[2:0];
		end
	end

	// ==================== address map
	// ROM page 2 is the 128K editor, page 3 the 48K BASIC
	assign page_rom = {1'b1, zx48 | page_reg[4]};
	assign window   = bus.addr[15:14];

	always_comb begin
		case (window)
			2'd1:    bank = `BANK_4000;
			2'd2:    bank = `BANK_8000;
			default: bank = {page_ext, page_reg[2:0]};
		endcase

		if (window == 2'd0)
			ram_addr = ram_addr_t'({`ROM_BASE, page_rom, bus.addr[13:0]});
		else
			ram_addr = ram_addr_t'({bank, bus.addr[13:0]});
	end

	assign ram_rd  = bus.mem_rd;
	assign ram_we  = bus.mem_wr & (window != 2'd0);
	assign ram_din = bus.dout;

endmodule

/* src/ula_port.sv */
/*
 * Port FE latch and the two-channel audio mix.
 * Audio words are unsigned and lag the inputs by one clock.
 */
`timescale 1ns/100ps
`include "zx_host_params.svh"

module ula_port import zx_host_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	zx_bus_if.target   bus,
	input  logic [4:0] key_data,
	input  logic       ear_in,
	input  byte_t      psg_ch_a,
	input  byte_t      psg_ch_b,
	input  byte_t      psg_ch_c,
	output byte_t      ula_din,
	output logic [2:0] border_color,
	output audio_t     audio_l,
	output audio_t     audio_r
);

	logic       ula_wr;
	logic       ear_out, mic_out;
	logic [9:0] beep, mix_l, mix_r;

	assign ula_wr = bus.io_wr_stb & ((bus.addr & `PORT_ULA_MASK) == '0);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			mic_out      <= 1'b0;
			ear_out      <= 1'b0;
		end else if (ula_wr) begin
			border_color <= bus.dout[2:0];
			mic_out      <= bus.dout[3];
			ear_out      <= bus.dout[4];
		end
	end

	// Bits 7 and 5 read back high
	assign ula_din = {1'b1, ~ear_in, 1'b1, key_data};

	// ==================== audio mix
	// Speaker bits at weights 128, 64, 32; channel B shared by both sides
	assign beep  = {2'b00, ear_out, mic_out, ear_in, 5'b00000};
	assign mix_l = {1'b0, psg_ch_a, 1'b0} + {2'b00, psg_ch_b} + beep;
	assign mix_r = {1'b0, psg_ch_c, 1'b0} + {2'b00, psg_ch_b} + beep;

	always_ff @(posedge clk_sys) begin
		audio_l <= {mix_l, 6'd0};
		audio_r <= {mix_r, 6'd0};
	end

endmodule

/* src/zx_host.sv */
/*
 * CPU-side glue of the host board. The Z80 core, RAM and sound chip
 * sit outside; their pins connect here directly.
 */
`timescale 1ns/100ps

module zx_host import zx_host_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       mreq_n,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	input  logic       m1_n,
	input  cpu_addr_t  addr,
	input  byte_t      cpu_dout,
	input  byte_t      ram_dout,
	input  logic       ram_ready,
	input  byte_t      psg_dout,
	input  byte_t      psg_ch_a,
	input  byte_t      psg_ch_b,
	input  byte_t      psg_ch_c,
	input  logic [4:0] key_data,
	input  logic       ear_in,
	input  turbo_e     turbo_sel,
	input  logic       pause,
	input  mem_model_e mem_model,
	output byte_t      cpu_din,
	output ram_addr_t  ram_addr,
	output logic       ram_rd,
	output logic       ram_we,
	output byte_t      ram_din,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n,
	output logic       ce_psg,
	output logic [2:0] border_color,
	output audio_t     audio_l,
	output audio_t     audio_r
);

	byte_t ula_din;

	zx_bus_if bus ();

	bus_decoder u_bus_decoder (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mreq_n   (mreq_n),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.addr     (addr),
		.cpu_dout (cpu_dout),
		.ram_dout (ram_dout),
		.psg_dout (psg_dout),
		.ula_din  (ula_din),
		.bus      (bus.master),
		.cpu_din  (cpu_din)
	);

	clock_enables u_clock_enables (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.turbo_sel (turbo_sel),
		.pause     (pause),
		.ram_ready (ram_ready),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n),
		.ce_psg    (ce_psg)
	);

	memory_pager u_memory_pager (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mem_model (mem_model),
		.bus       (bus.target),
		.ram_addr  (ram_addr),
		.ram_rd    (ram_rd),
		.ram_we    (ram_we),
		.ram_din   (ram_din)
	);

	ula_port u_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus.target),
		.key_data     (key_data),
		.ear_in       (ear_in),
		.psg_ch_a     (psg_ch_a),
		.psg_ch_b     (psg_ch_b),
		.psg_ch_c     (psg_ch_c),
		.ula_din      (ula_din),
		.border_color (border_color),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

endmodule

/* tests/zx_host_tb.sv */
/*
 * Command-driven testbench for the host glue. Each line of the input file
 * holds seven hex words: a command code and six arguments.
 * Outputs are sampled on the falling clock edge.
 */
`timescale 1ns/100ps

module zx_host_tb import zx_host_pkg::*; ();

	localparam int MAX_CMDS       = 64;
	localparam int ARGS           = 7;
	localparam int CYCLES_PER_CMD = 200;

	logic       clk_sys, reset;
	logic       mreq_n, iorq_n, rd_n, wr_n, m1_n;
	cpu_addr_t  addr;
	byte_t      cpu_dout, ram_dout, psg_dout, psg_ch_a, psg_ch_b, psg_ch_c;
	logic       ram_ready, ear_in, pause;
	logic [4:0] key_data;
	turbo_e     turbo_sel;
	mem_model_e mem_model;
	byte_t      cpu_din, ram_din;
	ram_addr_t  ram_addr;
	logic       ram_rd, ram_we, ce_cpu_p, ce_cpu_n, ce_psg;
	logic [2:0] border_color;
	audio_t     audio_l, audio_r;

	logic [31:0] cmds [0:MAX_CMDS*ARGS-1];
	int unsigned cycles = 0;
	int unsigned limit  = 0;

	zx_host UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Watchdog armed once the command count is known
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("TESTS FAILED");
			$fatal(1, "Run did not finish within %0d cycles", limit);
		end
	end

	// ==================== checks
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic check_addr(input string name, input ram_addr_t got, input ram_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_audio(input string name, input audio_t got, input audio_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_period(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("mismatch %s period: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("mismatch %s pulses: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// ==================== drivers
	task automatic next_drive;
		@(posedge clk_sys);
		#5;
	endtask

	task automatic bus_idle;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
	endtask

	task automatic do_reset(input mem_model_e model);
		next_drive();
		mem_model = model;
		reset     = 1'b1;
		repeat (10) @(posedge clk_sys);
		#5;
		reset = 1'b0;
	endtask

	function automatic logic enable_bit(input int which);
		case (which)
			0:       return ce_cpu_p;
			1:       return ce_cpu_n;
			default: return ce_psg;
		endcase
	endfunction

	// Counts falling edges up to the next pulse of the chosen enable
	task automatic wait_enable(input int which, output int gap);
		gap = 0;
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!enable_bit(which));
	endtask

	// ==================== command loop
	initial begin
		int n, base, gap, cnt_p, cnt_psg;
		logic [31:0] op, a, b, c, d, e, f;

		reset     = 1'b1;
		bus_idle();
		addr      = '0;
		cpu_dout  = '0;
		ram_dout  = '0;
		psg_dout  = '0;
		psg_ch_a  = '0;
		psg_ch_b  = '0;
		psg_ch_c  = '0;
		ram_ready = 1'b1;
		ear_in    = 1'b0;
		pause     = 1'b0;
		key_data  = '0;
		turbo_sel = TURBO_X1;
		mem_model = MEM_128K;

		$readmemh("tests/zx_host_input.txt", cmds);
		n = 0;
		while (n < MAX_CMDS && cmds[n*ARGS] != 0)
			n++;
		if (n == 0)
			abort_run("input file holds no commands");
		limit = n * CYCLES_PER_CMD;

		do_reset(MEM_128K);

		for (int i = 0; i < n; i++) begin
			base = i * ARGS;
			op   = cmds[base];
			a    = cmds[base+1];
			b    = cmds[base+2];
			c    = cmds[base+3];
			d    = cmds[base+4];
			e    = cmds[base+5];
			f    = cmds[base+6];
			case (op)
				32'h01: do_reset(mem_model_e'(a[1:0]));
				32'h02, 32'h03: begin
					next_drive();
					addr     = a[15:0];
					mreq_n   = 1'b0;
					ram_dout = c[7:0];
					cpu_dout = c[7:0];
					if (op == 32'h02)
						rd_n = 1'b0;
					else
						wr_n = 1'b0;
					@(negedge clk_sys);
					if (op == 32'h02) begin
						check_addr("ram_addr", ram_addr, b[24:0]);
						check_bit("ram_rd", ram_rd, 1'b1);
						check_byte("cpu_din", cpu_din, c[7:0]);
					end else begin
						check_bit("ram_we", ram_we, b[0]);
						check_byte("ram_din", ram_din, c[7:0]);
					end
					next_drive();
					bus_idle();
				end
				32'h04: begin
					next_drive();
					addr     = a[15:0];
					cpu_dout = b[7:0];
					iorq_n   = 1'b0;
					wr_n     = 1'b0;
					// Strobe on the first edge, register on the second
					repeat (2) @(posedge clk_sys);
					#5;
					bus_idle();
				end
				32'h05: begin
					next_drive();
					addr     = a[15:0];
					key_data = b[4:0];
					ear_in   = c[0];
					psg_dout = d[7:0];
					iorq_n   = 1'b0;
					rd_n     = 1'b0;
					@(negedge clk_sys);
					check_byte("cpu_din", cpu_din, e[7:0]);
					next_drive();
					bus_idle();
				end
				32'h06: begin
					next_drive();
					psg_ch_a = a[7:0];
					psg_ch_b = b[7:0];
					psg_ch_c = c[7:0];
					ear_in   = d[0];
					repeat (3) @(negedge clk_sys);
					check_audio("audio_l", audio_l, e[15:0]);
					check_audio("audio_r", audio_r, f[15:0]);
				end
				32'h07: begin
					@(negedge clk_sys);
					check_byte("border_color", byte_t'(border_color), a[7:0]);
				end
				32'h08: begin
					next_drive();
					turbo_sel = turbo_e'(a[1:0]);
					// The next ce_cpu_n slot takes the new level
					wait_enable(1, gap);
					wait_enable(0, gap);
					repeat (3) begin
						wait_enable(0, gap);
						check_period("ce_cpu_p", gap, int'(b));
					end
					// ce_cpu_n comes half a period after ce_cpu_p
					wait_enable(1, gap);
					check_period("ce_cpu_n", gap, int'(b) / 2);
				end
				32'h09: begin
					next_drive();
					pause   = 1'b1;
					cnt_p   = 0;
					cnt_psg = 0;
					repeat (a) @(negedge clk_sys);
					repeat (b) begin
						@(negedge clk_sys);
						cnt_p   += int'(ce_cpu_p);
						cnt_psg += int'(ce_psg);
					end
					check_count("ce_cpu_p", cnt_p, 0);
					check_count("ce_psg", cnt_psg, 0);
					next_drive();
					pause = 1'b0;
				end
				32'h0A: begin
					wait_enable(2, gap);
					wait_enable(2, gap);
					check_period("ce_psg", gap, int'(a));
				end
				default: abort_run($sformatf("unknown command %0h on line %0d", op, i));
			endcase
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* tests/zx_host_input.txt */
// cmd a b c d e f: 01 reset model, 02 mem read addr exp_ram_addr data, 03 mem write addr exp_we data
// 04 io write port data, 05 io read port keys ear psg exp_din, 06 audio a b c ear exp_l exp_r
// 07 border exp, 08 turbo level exp_period, 09 pause skip cycles, 0A psg exp_period, 00 end
01 0 0 0 0 0 0
02 0123 17C123 A5 0 0 0
04 7FFD 07 0 0 0 0
02 CDEF 000DEF 00 0 0 0
01 1 0 0 0 0 0
02 0123 178123 3C 0 0 0
02 4567 014567 00 0 0 0
02 89AB 0089AB 00 0 0 0
02 CDEF 000DEF 00 0 0 0
04 7FFD 13 0 0 0 0
02 0123 17C123 00 0 0 0
02 CDEF 00CDEF 00 0 0 0
04 7FFD 27 0 0 0 0
02 CDEF 01CDEF 00 0 0 0
04 7FFD 01 0 0 0 0
02 CDEF 01CDEF 00 0 0 0
02 0123 178123 00 0 0 0
03 0123 0 5A 0 0 0
03 4567 1 C3 0 0 0
01 2 0 0 0 0 0
04 7FFD C5 0 0 0 0
02 CDEF 074DEF 00 0 0 0
01 3 0 0 0 0 0
04 DFFD 05 0 0 0 0
02 CDEF 0A0DEF 00 0 0 0
04 7FFD 02 0 0 0 0
02 CDEF 0A8DEF 00 0 0 0
04 00FE 1D 0 0 0 0
07 5 0 0 0 0 0
06 10 20 30 1 4800 5800
06 FF 80 01 1 D780 5880
05 00FE 15 1 5A B5 0
05 00FE 0A 0 5A EA 0
05 FFFD 15 1 5A 5A 0
05 00FF 15 1 5A FF 0
0A 40 0 0 0 0 0
08 0 20 0 0 0 0
08 1 10 0 0 0 0
08 2 08 0 0 0 0
08 3 04 0 0 0 0
09 40 64 0 0 0 0
08 0 20 0 0 0 0
00 0 0 0 0 0 0

/* zx_host.f */
+incdir+src
src/zx_host_pkg.sv
src/zx_bus_if.sv
src/bus_decoder.sv
src/clock_enables.sv
src/memory_pager.sv
src/ula_port.sv
src/zx_host.sv
tests/zx_host_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing -Wno-fatal -f zx_host.f \
	--top-module zx_host_tb --Mdir obj_dir -o zx_host_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/zx_host_sim; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0
